//--- hw/avr_ctrl_pkg.sv
package avr_ctrl_pkg;

        typedef logic [7:0] opcode_t;           // Instruction identifier
        typedef logic [7:0] sreg_t;             // Status register
        typedef logic [2:0] alu_sel_t;          // ALU operation select

        typedef enum logic {
                PH_FIRST,
                PH_SECOND
        } phase_t;

        typedef enum logic [2:0] {
                BR_NONE,
                BR_ALWAYS,
                BR_C_SET,
                BR_C_CLR,
                BR_Z_SET,
                BR_Z_CLR
        } br_cond_t;

        localparam opcode_t OP_NOP  = 8'h00;
        localparam opcode_t OP_ADC  = 8'h01;
        localparam opcode_t OP_ADD  = 8'h02;
        localparam opcode_t OP_AND  = 8'h03;
        localparam opcode_t OP_BRCC = 8'h04;
        localparam opcode_t OP_BRCS = 8'h05;
        localparam opcode_t OP_BREQ = 8'h06;
        localparam opcode_t OP_BRNE = 8'h08;
        localparam opcode_t OP_CLI  = 8'h0A;
        localparam opcode_t OP_CP   = 8'h0C;
        localparam opcode_t OP_CPI  = 8'h0D;
        localparam opcode_t OP_DEC  = 8'h0F;
        localparam opcode_t OP_EOR  = 8'h10;
        localparam opcode_t OP_IN   = 8'h11;
        localparam opcode_t OP_INC  = 8'h12;
        localparam opcode_t OP_LDI  = 8'h20;
        localparam opcode_t OP_LSR  = 8'h24;
        localparam opcode_t OP_MOV  = 8'h25;
        localparam opcode_t OP_MUL  = 8'h26;
        localparam opcode_t OP_OR   = 8'h27;
        localparam opcode_t OP_ORI  = 8'h28;
        localparam opcode_t OP_OUT  = 8'h29;
        localparam opcode_t OP_POP  = 8'h2A;
        localparam opcode_t OP_PUSH = 8'h2B;
        localparam opcode_t OP_RJMP = 8'h2F;
        localparam opcode_t OP_ROL  = 8'h30;
        localparam opcode_t OP_ROR  = 8'h31;
        localparam opcode_t OP_SEI  = 8'h32;
        localparam opcode_t OP_SUB  = 8'h40;
        localparam opcode_t OP_SUBI = 8'h41;

        localparam alu_sel_t ALU_ADD = 3'd0;
        localparam alu_sel_t ALU_SUB = 3'd1;
        localparam alu_sel_t ALU_MUL = 3'd2;
        localparam alu_sel_t ALU_ROL = 3'd3;
        localparam alu_sel_t ALU_SHR = 3'd4;    // LSR and ROR share it
        localparam alu_sel_t ALU_AND = 3'd5;
        localparam alu_sel_t ALU_OR  = 3'd6;
        localparam alu_sel_t ALU_EOR = 3'd7;

        localparam logic [2:0] FLAG_C = 3'd0;   // Carry bit in sreg_t
        localparam logic [2:0] FLAG_Z = 3'd1;   // Zero bit in sreg_t

endpackage

//--- hw/opcode_decoder.sv
`timescale 1ns/10ps

module opcode_decoder (
        input  avr_ctrl_pkg::opcode_t   opcode,
        input  avr_ctrl_pkg::phase_t    phase,
        output logic                    pc_inc,
        output logic                    gp_reg_write,
        output avr_ctrl_pkg::alu_sel_t  alu_sel,
        output logic                    use_carry,
        output logic                    status_reg_sel,
        output logic                    io_only_flag,
        output logic                    memory_write_en,
        output avr_ctrl_pkg::br_cond_t  br_cond,
        output logic                    two_cycle
);

        import avr_ctrl_pkg::*;

        logic second;

        assign second = (phase == PH_SECOND);   // Selects the second word

        always_comb
        begin
                pc_inc          = 1'b0;
                gp_reg_write    = 1'b0;
                alu_sel         = ALU_ADD;
                use_carry       = 1'b0;
                status_reg_sel  = 1'b0;
                io_only_flag    = 1'b0;
                memory_write_en = 1'b0;
                br_cond         = BR_NONE;
                two_cycle       = 1'b0;

                case (opcode)
                OP_NOP:
                begin
                        // All-zero word from the defaults
                end
                OP_ADC:
                begin
                        pc_inc       = 1'b1;
                        gp_reg_write = 1'b1;
                        use_carry    = 1'b1;    // Add with carry in
                end
                OP_ADD, OP_INC, OP_LDI, OP_MOV:
                begin
                        pc_inc       = 1'b1;
                        gp_reg_write = 1'b1;
                end
                OP_AND:
                begin
                        pc_inc       = 1'b1;
                        gp_reg_write = 1'b1;
                        alu_sel      = ALU_AND;
                end
                OP_DEC, OP_SUB, OP_SUBI:
                begin
                        pc_inc       = 1'b1;
                        gp_reg_write = 1'b1;
                        alu_sel      = ALU_SUB;
                end
                OP_EOR:
                begin
                        pc_inc       = 1'b1;
                        gp_reg_write = 1'b1;
                        alu_sel      = ALU_EOR;
                end
                OP_LSR, OP_ROR:
                begin
                        pc_inc       = 1'b1;
                        gp_reg_write = 1'b1;
                        alu_sel      = ALU_SHR;
                end
                OP_OR, OP_ORI:
                begin
                        pc_inc       = 1'b1;
                        gp_reg_write = 1'b1;
                        alu_sel      = ALU_OR;
                end
                OP_ROL:
                begin
                        pc_inc       = 1'b1;
                        gp_reg_write = 1'b1;
                        alu_sel      = ALU_ROL;
                end
                OP_CP, OP_CPI:
                begin
                        pc_inc  = 1'b1;
                        alu_sel = ALU_SUB;      // Flags only, no writeback
                end
                OP_IN:
                begin
                        pc_inc         = 1'b1;
                        gp_reg_write   = 1'b1;
                        status_reg_sel = 1'b1;
                        io_only_flag   = 1'b1;
                end
                OP_OUT:
                begin
                        pc_inc          = 1'b1;
                        memory_write_en = 1'b1;
                end
                OP_CLI, OP_SEI:
                begin
                        pc_inc          = 1'b1;
                        status_reg_sel  = 1'b1;
                        io_only_flag    = 1'b1;
                        memory_write_en = 1'b1;
                end
                OP_BRCC:
                begin
                        two_cycle = 1'b1;
                        pc_inc    = ~second;
                        if (!second)
                                br_cond = BR_C_CLR;
                end
                OP_BRCS:
                begin
                        two_cycle = 1'b1;
                        pc_inc    = ~second;
                        if (!second)
                                br_cond = BR_C_SET;
                end
                OP_BREQ:
                begin
                        two_cycle = 1'b1;
                        pc_inc    = ~second;
                        if (!second)
                                br_cond = BR_Z_SET;
                end
                OP_BRNE:
                begin
                        two_cycle = 1'b1;
                        pc_inc    = ~second;
                        if (!second)
                                br_cond = BR_Z_CLR;
                end
                OP_RJMP:
                begin
                        two_cycle = 1'b1;
                        pc_inc    = ~second;
                        if (!second)
                                br_cond = BR_ALWAYS;
                end
                OP_MUL:
                begin
                        two_cycle    = 1'b1;
                        pc_inc       = ~second;
                        gp_reg_write = 1'b1;    // Both halves of the product
                        alu_sel      = ALU_MUL;
                end
                OP_PUSH:
                begin
                        two_cycle       = 1'b1;
                        pc_inc          = ~second;
                        memory_write_en = 1'b1;
                        if (second)
                                alu_sel = ALU_SUB;      // Stack pointer decrement
                end
                OP_POP:
                begin
                        two_cycle       = 1'b1;
                        pc_inc          = ~second;
                        memory_write_en = ~second;
                        gp_reg_write    = second;       // Load popped byte
                end
                default:
                begin
                        // Unlisted opcodes issue one NOP word
                end
                endcase
        end

endmodule

//--- hw/instr_sequencer.sv
`timescale 1ns/10ps

module instr_sequencer (
        input  logic                    clk,
        input  logic                    rst,
        input  logic                    instr_valid,
        input  avr_ctrl_pkg::opcode_t   instr_id,
        input  avr_ctrl_pkg::sreg_t     status_register,
        input  logic                    pc_inc_d,
        input  logic                    gp_reg_write_d,
        input  avr_ctrl_pkg::alu_sel_t  alu_sel_d,
        input  logic                    use_carry_d,
        input  logic                    status_reg_sel_d,
        input  logic                    io_only_flag_d,
        input  logic                    memory_write_en_d,
        input  avr_ctrl_pkg::br_cond_t  br_cond,
        input  logic                    two_cycle,
        output logic                    instr_ready,
        output avr_ctrl_pkg::opcode_t   opcode,
        output avr_ctrl_pkg::phase_t    phase,
        output logic                    pc_inc,
        output logic                    pc_overwrite,
        output logic                    gp_reg_write,
        output avr_ctrl_pkg::alu_sel_t  alu_sel,
        output logic                    use_carry,
        output logic                    status_reg_sel,
        output logic                    io_only_flag,
        output logic                    memory_write_en
);

        import avr_ctrl_pkg::*;

        phase_t  phase_q;
        opcode_t opcode_q;      // Opcode held for the second word
        logic    accept;
        logic    issue;
        logic    taken;

        assign instr_ready = (phase_q == PH_FIRST);     // Stall during second word
        assign accept      = instr_valid & instr_ready;
        assign issue       = accept | (phase_q == PH_SECOND);
        assign opcode      = (phase_q == PH_SECOND) ? opcode_q : instr_id;
        assign phase       = phase_q;

        // Flags are sampled at the accepting edge
        always_comb
        begin
                case (br_cond)
                BR_ALWAYS: taken = 1'b1;
                BR_C_SET:  taken = status_register[FLAG_C];
                BR_C_CLR:  taken = ~status_register[FLAG_C];
                BR_Z_SET:  taken = status_register[FLAG_Z];
                BR_Z_CLR:  taken = ~status_register[FLAG_Z];
                default:   taken = 1'b0;
                endcase
        end

        always_ff @(posedge clk)
        begin
                if (rst)
                        phase_q <= PH_FIRST;
                else
                begin
                        case (phase_q)
                        PH_FIRST:
                                if (accept && two_cycle)
                                        phase_q <= PH_SECOND;
                        PH_SECOND:
                                phase_q <= PH_FIRST;    // Always back after one cycle
                        endcase
                end
        end

        always_ff @(posedge clk)
        begin
                if (accept)
                        opcode_q <= instr_id;
        end

        always_ff @(posedge clk)
        begin
                if (rst || !issue)
                begin
                        pc_inc          <= 1'b0;        // Idle word
                        pc_overwrite    <= 1'b0;
                        gp_reg_write    <= 1'b0;
                        alu_sel         <= '0;
                        use_carry       <= 1'b0;
                        status_reg_sel  <= 1'b0;
                        io_only_flag    <= 1'b0;
                        memory_write_en <= 1'b0;
                end
                else
                begin
                        pc_inc          <= pc_inc_d;
                        pc_overwrite    <= accept & taken;
                        gp_reg_write    <= gp_reg_write_d;
                        alu_sel         <= alu_sel_d;
                        use_carry       <= use_carry_d;
                        status_reg_sel  <= status_reg_sel_d;
                        io_only_flag    <= io_only_flag_d;
                        memory_write_en <= memory_write_en_d;
                end
        end

endmodule

//--- hw/avr_control_unit.sv
`timescale 1ns/10ps

module avr_control_unit (
        input  logic                    clk,
        input  logic                    rst,
        input  logic                    instr_valid,
        input  avr_ctrl_pkg::opcode_t   instr_id,
        input  avr_ctrl_pkg::sreg_t     status_register,
        output logic                    instr_ready,
        output logic                    pc_inc,
        output logic                    pc_overwrite,
        output logic                    gp_reg_write,
        output avr_ctrl_pkg::alu_sel_t  alu_sel,
        output logic                    use_carry,
        output logic                    status_reg_sel,
        output logic                    io_only_flag,
        output logic                    memory_write_en
);

        import avr_ctrl_pkg::*;

        opcode_t  opcode;               // Current or held opcode
        phase_t   phase;
        logic     pc_inc_d;
        logic     gp_reg_write_d;
        alu_sel_t alu_sel_d;
        logic     use_carry_d;
        logic     status_reg_sel_d;
        logic     io_only_flag_d;
        logic     memory_write_en_d;
        br_cond_t br_cond;
        logic     two_cycle;

        opcode_decoder u_decoder (
                .opcode          (opcode),
                .phase           (phase),
                .pc_inc          (pc_inc_d),
                .gp_reg_write    (gp_reg_write_d),
                .alu_sel         (alu_sel_d),
                .use_carry       (use_carry_d),
                .status_reg_sel  (status_reg_sel_d),
                .io_only_flag    (io_only_flag_d),
                .memory_write_en (memory_write_en_d),
                .br_cond         (br_cond),
                .two_cycle       (two_cycle)
        );

        instr_sequencer u_sequencer (
                .clk               (clk),
                .rst               (rst),
                .instr_valid       (instr_valid),
                .instr_id          (instr_id),
                .status_register   (status_register),
                .pc_inc_d          (pc_inc_d),
                .gp_reg_write_d    (gp_reg_write_d),
                .alu_sel_d         (alu_sel_d),
                .use_carry_d       (use_carry_d),
                .status_reg_sel_d  (status_reg_sel_d),
                .io_only_flag_d    (io_only_flag_d),
                .memory_write_en_d (memory_write_en_d),
                .br_cond           (br_cond),
                .two_cycle         (two_cycle),
                .instr_ready       (instr_ready),
                .opcode            (opcode),
                .phase             (phase),
                .pc_inc            (pc_inc),
                .pc_overwrite      (pc_overwrite),
                .gp_reg_write      (gp_reg_write),
                .alu_sel           (alu_sel),
                .use_carry         (use_carry),
                .status_reg_sel    (status_reg_sel),
                .io_only_flag      (io_only_flag),
                .memory_write_en   (memory_write_en)
        );

endmodule

//--- testbench/avr_control_unit_assert.sv
`timescale 1ns/10ps

module avr_control_unit_assert (
        input logic                     clk,
        input logic                     rst,
        input logic                     instr_valid,
        input logic                     instr_ready,
        input logic                     two_cycle,
        input logic                     pc_inc,
        input logic                     pc_overwrite,
        input logic                     gp_reg_write,
        input avr_ctrl_pkg::alu_sel_t   alu_sel,
        input logic                     use_carry,
        input logic                     status_reg_sel,
        input logic                     io_only_flag,
        input logic                     memory_write_en
);

        int unsigned fail_count = 0;    // Failed assertions so far
        logic [9:0]  ctrl_word;
        logic        accept;

        assign ctrl_word = {pc_inc, pc_overwrite, gp_reg_write, alu_sel, use_carry,
                            status_reg_sel, io_only_flag, memory_write_en};
        assign accept    = instr_valid & instr_ready;

        overwrite_needs_inc: assert property (@(posedge clk) disable iff (rst)
                pc_overwrite |-> pc_inc)
        else
        begin
                $error("pc_overwrite set without pc_inc");
                fail_count++;
        end

        reset_clears: assert property (@(posedge clk)
                rst |=> (ctrl_word == '0) && instr_ready)
        else
        begin
                $error("Control word or instr_ready wrong after reset");
                fail_count++;
        end

        // Two-cycle opcodes stall the input for exactly one cycle
        stall_after_two: assert property (@(posedge clk) disable iff (rst)
                accept && two_cycle |=> !instr_ready)
        else
        begin
                $error("instr_ready high right after a two-cycle opcode");
                fail_count++;
        end

        no_stall_after_one: assert property (@(posedge clk) disable iff (rst)
                accept && !two_cycle |=> instr_ready)
        else
        begin
                $error("instr_ready low after a one-cycle opcode");
                fail_count++;
        end

        stall_one_cycle: assert property (@(posedge clk) disable iff (rst)
                !instr_ready |=> instr_ready)
        else
        begin
                $error("instr_ready low for more than one cycle");
                fail_count++;
        end

endmodule

bind avr_control_unit avr_control_unit_assert u_assert (
        .clk             (clk),
        .rst             (rst),
        .instr_valid     (instr_valid),
        .instr_ready     (instr_ready),
        .two_cycle       (two_cycle),
        .pc_inc          (pc_inc),
        .pc_overwrite    (pc_overwrite),
        .gp_reg_write    (gp_reg_write),
        .alu_sel         (alu_sel),
        .use_carry       (use_carry),
        .status_reg_sel  (status_reg_sel),
        .io_only_flag    (io_only_flag),
        .memory_write_en (memory_write_en)
);

//--- testbench/tb_avr_control_unit.sv
`timescale 1ns/10ps

module tb_avr_control_unit;

        import avr_ctrl_pkg::*;

        typedef logic [9:0] ctrl_word_t;        // pc_inc down to memory_write_en
        typedef logic [6:0] ctrl_flags_t;       // Word without the ALU select

        localparam int CLK_HALF = 4;

        logic           clk;
        logic           rst;
        logic           instr_valid;
        opcode_t        instr_id;
        sreg_t          status_register;
        logic           instr_ready;
        logic           pc_inc;
        logic           pc_overwrite;
        logic           gp_reg_write;
        alu_sel_t       alu_sel;
        logic           use_carry;
        logic           status_reg_sel;
        logic           io_only_flag;
        logic           memory_write_en;

        opcode_t        op_q[$];
        sreg_t          sreg_q[$];
        int             gap_q[$];
        ctrl_word_t     first_q[$];
        ctrl_word_t     second_q[$];
        int             len_q[$];

        integer         seed;
        int             cycle_count;
        int             cycle_limit;            // Zero until the vectors are loaded
        logic           pending;                // Second word still expected
        ctrl_word_t     pending_word;

        avr_control_unit u_dut (
                .clk             (clk),
                .rst             (rst),
                .instr_valid     (instr_valid),
                .instr_id        (instr_id),
                .status_register (status_register),
                .instr_ready     (instr_ready),
                .pc_inc          (pc_inc),
                .pc_overwrite    (pc_overwrite),
                .gp_reg_write    (gp_reg_write),
                .alu_sel         (alu_sel),
                .use_carry       (use_carry),
                .status_reg_sel  (status_reg_sel),
                .io_only_flag    (io_only_flag),
                .memory_write_en (memory_write_en)
        );

        initial
        begin
                clk = 1'b0;
                forever #CLK_HALF clk = ~clk;
        end

        always @(posedge clk)
        begin
                cycle_count = cycle_count + 1;
                if (u_dut.u_assert.fail_count != 0)
                begin
                        $display("%0d assertion failures seen", u_dut.u_assert.fail_count);
                        abort_run();
                end
                else if (cycle_limit > 0 && cycle_count > cycle_limit)
                begin
                        $display("Timeout: run took more than %0d cycles", cycle_limit);
                        abort_run();
                end
        end

        task automatic abort_run();
                $display("TEST FAILED");
                $fatal(1, "Simulation stopped on error");
        endtask

        task automatic check_ctrl_word(input ctrl_flags_t got, input ctrl_flags_t exp,
                                       input string tag);
                string names [7];
                int    i;

                names = '{"memory_write_en", "io_only_flag", "status_reg_sel", "use_carry",
                          "gp_reg_write", "pc_overwrite", "pc_inc"};
                for (i = 0; i < 7; i++)
                begin
                        if (got[i] !== exp[i])
                        begin
                                $display("Mismatch %s at %s: got %h expected %h",
                                         names[i], tag, got[i], exp[i]);
                                abort_run();
                        end
                end
        endtask

        task automatic check_alu_sel(input alu_sel_t got, input alu_sel_t exp, input string tag);
                if (got !== exp)
                begin
                        $display("Mismatch alu_sel at %s: got %h expected %h", tag, got, exp);
                        abort_run();
                end
        endtask

        task automatic check_ready(input bit got, input bit exp, input string tag);
                if (got !== exp)
                begin
                        $display("Mismatch instr_ready at %s: got %h expected %h", tag, got, exp);
                        abort_run();
                end
        endtask

        task automatic check_outputs(input ctrl_word_t exp, input bit ready_exp, input string tag);
                check_ctrl_word({pc_inc, pc_overwrite, gp_reg_write, use_carry, status_reg_sel,
                                 io_only_flag, memory_write_en}, {exp[9:7], exp[3:0]}, tag);
                check_alu_sel(alu_sel, exp[6:4], tag);
                check_ready(instr_ready, ready_exp, tag);
        endtask

        task automatic load_vectors();
                integer      fd;
                string       line;
                int          n;
                opcode_t     op;
                sreg_t       sr;
                int          gap;
                ctrl_word_t  w1;
                ctrl_word_t  w2;
                int          len;
                logic [31:0] rnd;
                int          extra;
                int          total;

                total = 0;
                fd = $fopen("testbench/ctrl_input.txt", "r");
                if (fd == 0)
                begin
                        $display("Cannot open testbench/ctrl_input.txt");
                        abort_run();
                end
                while ($fgets(line, fd) != 0)
                begin
                        if (line.len() < 2 || line.getc(0) == "#")
                                continue;       // Blank or column description
                        n = $sscanf(line, "%h %h %d %h %h %d", op, sr, gap, w1, w2, len);
                        if (n != 6 || len < 1 || len > 2)
                        begin
                                $display("Malformed vector line: %s", line);
                                abort_run();
                        end
                        rnd   = $random(seed);
                        extra = (rnd[3:2] == 2'b00) ? int'(rnd[1:0]) : 0;       // Sometimes longer idle
                        op_q.push_back(op);
                        sreg_q.push_back(sr);
                        gap_q.push_back(gap + extra);
                        first_q.push_back(w1);
                        second_q.push_back(w2);
                        len_q.push_back(len);
                        total = total + gap + extra + len;
                end
                $fclose(fd);
                if (op_q.size() == 0)
                begin
                        $display("No test vectors found in testbench/ctrl_input.txt");
                        abort_run();
                end
                cycle_limit = 4 * total + 50;
        endtask

        // Idle cycle that may still show a pending second word
        task automatic idle_cycle(input string tag);
                @(negedge clk);
                check_outputs(pending ? pending_word : ctrl_word_t'(0), 1'b1, tag);
                pending = 1'b0;
        endtask

        task automatic run_vector(input int i);
                string tag;
                int    g;

                tag = $sformatf("vector %0d opcode %h", i, op_q[i]);
                instr_valid = 1'b0;
                for (g = 0; g < gap_q[i]; g++)
                        idle_cycle({tag, " gap"});
                instr_valid     = 1'b1;
                instr_id        = op_q[i];
                status_register = sreg_q[i];
                while (!instr_ready)
                        idle_cycle({tag, " stall"});    // Held until the stall ends
                @(negedge clk);
                check_outputs(first_q[i], len_q[i] == 1, {tag, " first word"});
                pending      = (len_q[i] == 2);
                pending_word = second_q[i];
        endtask

        initial
        begin
                int i;

                rst             = 1'b1;
                instr_valid     = 1'b0;
                instr_id        = OP_NOP;
                status_register = '0;
                seed            = 32'hcd033b7a;
                cycle_count     = 0;
                cycle_limit     = 0;
                pending         = 1'b0;
                pending_word    = '0;
                load_vectors();
                repeat (3) @(posedge clk);
                @(negedge clk);
                rst = 1'b0;
                check_outputs('0, 1'b1, "after reset");
                for (i = 0; i < op_q.size(); i++)
                        run_vector(i);
                instr_valid = 1'b0;
                idle_cycle("drain");
                idle_cycle("drain");
                if (u_dut.u_assert.fail_count != 0)
                begin
                        $display("%0d assertion failures seen", u_dut.u_assert.fail_count);
                        abort_run();
                end
                else
                begin
                        $display("TEST OK");
                        $finish;
                end
        end

endmodule

//--- testbench/ctrl_input.txt
# opcode sreg gap word1 word2 length
# opcode, sreg and words in hex, gap and length in decimal
01 00 0 288 000 1
02 00 1 280 000 1
03 00 0 2d0 000 1
0c 00 0 210 000 1
0d 00 2 210 000 1
0f 00 0 290 000 1
10 00 0 2f0 000 1
11 00 0 286 000 1
12 00 1 280 000 1
20 00 0 280 000 1
24 00 0 2c0 000 1
25 00 0 280 000 1
27 00 0 2e0 000 1
28 00 1 2e0 000 1
29 00 0 201 000 1
30 00 0 2b0 000 1
31 00 0 2c0 000 1
40 00 0 290 000 1
41 00 0 290 000 1
0a 00 0 207 000 1
32 00 0 207 000 1
04 00 0 300 000 2
04 01 0 200 000 2
05 01 1 300 000 2
05 00 0 200 000 2
06 02 0 300 000 2
06 00 0 200 000 2
08 00 0 300 000 2
08 02 0 200 000 2
2f 03 0 300 000 2
26 00 0 2a0 0a0 2
2b 00 0 201 011 2
2a 00 0 201 080 2
07 03 0 000 000 1
13 00 0 000 000 1
ff 00 1 000 000 1
2a 00 2 201 080 2
00 00 0 000 000 1

//--- filelist.f
hw/avr_ctrl_pkg.sv
hw/opcode_decoder.sv
hw/instr_sequencer.sv
hw/avr_control_unit.sv
testbench/avr_control_unit_assert.sv
testbench/tb_avr_control_unit.sv

//--- Makefile
# Verilator flow for the AVR control unit
VERILATOR ?= verilator
TOP       ?= tb_avr_control_unit
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/10ps
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)
